// ==== verilog/aluPkg.sv ====
// shared ALU definitions
//   operation class enum
//   ALU control code enum
//   immediate extension mode enum
//   R-type funct and I-type opcode constants

package aluPkg;

  // ----------------------------------------
  // operation class from the main decoder
  // ----------------------------------------
  typedef enum logic [1:0] {
    // load/store address, rs plus sign-extended imm
    opMem    = 2'b00,
    // branch compare, rs minus rt
    opBranch = 2'b01,
    // immediate op, field holds the opcode
    opImm    = 2'b10,
    // register op, field holds the funct
    opRtype  = 2'b11
  } aluOpT;

  // ----------------------------------------
  // ALU control code
  // ----------------------------------------
  typedef enum logic [3:0] {
    ctrlAdd  = 4'h0,
    ctrlSub  = 4'h1,
    ctrlAnd  = 4'h2,
    ctrlOr   = 4'h3,
    ctrlXor  = 4'h4,
    ctrlNor  = 4'h5,
    ctrlSlt  = 4'h6,
    ctrlSltu = 4'h7,
    // unknown field, forces a zero result
    ctrlZero = 4'hf
  } aluCtrlT;

  // immediate extension mode
  typedef enum logic {
    extSign = 1'b0,
    extZero = 1'b1
  } extModeT;

  // R-type funct codes
  localparam logic [5:0] functAdd  = 6'b100000;
  localparam logic [5:0] functSub  = 6'b100010;
  localparam logic [5:0] functAnd  = 6'b100100;
  localparam logic [5:0] functOr   = 6'b100101;
  localparam logic [5:0] functXor  = 6'b100110;
  localparam logic [5:0] functNor  = 6'b100111;
  localparam logic [5:0] functSlt  = 6'b101010;
  localparam logic [5:0] functSltu = 6'b101011;

  // I-type opcodes
  localparam logic [5:0] opcAddi  = 6'b001000;
  localparam logic [5:0] opcSlti  = 6'b001010;
  localparam logic [5:0] opcSltiu = 6'b001011;
  localparam logic [5:0] opcAndi  = 6'b001100;
  localparam logic [5:0] opcOri   = 6'b001101;
  localparam logic [5:0] opcXori  = 6'b001110;

endpackage

// ==== verilog/aluIf.sv ====
// ALU operand and result interface
//   feed modport for the execute pipeline
//   core modport for the ALU itself

`timescale 1ns/1ps

interface aluIf
  import aluPkg::*;
#(
  parameter int dataWidth = 32
);

  // operands, registered in stage 1 of the pipeline
  logic [dataWidth-1:0] a;
  logic [dataWidth-1:0] b;
  // selected operation
  aluCtrlT              ctrl;
  // combinational outputs of the ALU
  logic [dataWidth-1:0] result;
  logic                 zero;

  // pipeline side
  modport feed (
    output a, b, ctrl,
    input  result, zero
  );

  // ALU side
  modport core (
    input  a, b, ctrl,
    output result, zero
  );

endinterface

// ==== verilog/aluDecode.sv ====
// ALU control decoder
//   maps operation class and funct/opcode field to an ALU control code,
//   the immediate select and the immediate extension mode

`timescale 1ns/1ps

module aluDecode
  import aluPkg::*;
(
  input  aluOpT      aluOp,
  input  logic [5:0] field,
  output aluCtrlT    ctrl,
  output logic       useImm,
  output extModeT    extMode
);

  always_comb begin
    // defaults cover the unknown cases
    ctrl    = ctrlZero;
    useImm  = 1'b0;
    extMode = extSign;

    case (aluOp)
      // ----------------------------------------
      // load/store address
      // ----------------------------------------
      opMem: begin
        ctrl    = ctrlAdd;
        useImm  = 1'b1;
        extMode = extSign;
      end

      // branch compare, b is always rt
      opBranch: begin
        ctrl   = ctrlSub;
        useImm = 1'b0;
      end

      // ----------------------------------------
      // immediate ops, field is the opcode
      // ----------------------------------------
      opImm: begin
        useImm = 1'b1;
        case (field)
          opcAddi: begin
            ctrl    = ctrlAdd;
            extMode = extSign;
          end
          opcSlti: begin
            ctrl    = ctrlSlt;
            extMode = extSign;
          end
          // sltiu still sign-extends, only the compare is unsigned
          opcSltiu: begin
            ctrl    = ctrlSltu;
            extMode = extSign;
          end
          // logical immediates take the zero-extended value
          opcAndi: begin
            ctrl    = ctrlAnd;
            extMode = extZero;
          end
          opcOri: begin
            ctrl    = ctrlOr;
            extMode = extZero;
          end
          opcXori: begin
            ctrl    = ctrlXor;
            extMode = extZero;
          end
          default: ctrl = ctrlZero;
        endcase
      end

      // ----------------------------------------
      // register ops, field is the funct
      // ----------------------------------------
      opRtype: begin
        useImm = 1'b0;
        case (field)
          functAdd:  ctrl = ctrlAdd;
          functSub:  ctrl = ctrlSub;
          functAnd:  ctrl = ctrlAnd;
          functOr:   ctrl = ctrlOr;
          functXor:  ctrl = ctrlXor;
          functNor:  ctrl = ctrlNor;
          functSlt:  ctrl = ctrlSlt;
          functSltu: ctrl = ctrlSltu;
          default:   ctrl = ctrlZero;
        endcase
      end

      default: ctrl = ctrlZero;
    endcase
  end

endmodule

// ==== verilog/alu.sv ====
// arithmetic/logic unit
//   add, sub, and, or, xor, nor
//   signed and unsigned set-less-than
//   zero flag derived from the result

`timescale 1ns/1ps

module alu
  import aluPkg::*;
#(
  parameter int dataWidth = 32
)
(
  aluIf.core bus
);

  // ----------------------------------------
  // internal results
  // ----------------------------------------
  // add and sub simply drop the carry out, so they wrap
  logic [dataWidth-1:0] sum;
  logic [dataWidth-1:0] diff;
  // compare outcomes
  logic                 ltSigned;
  logic                 ltUnsigned;
  logic [dataWidth-1:0] resultComb;

  assign sum  = bus.a + bus.b;
  assign diff = bus.a - bus.b;

  // signed compare treats the top bit as sign
  assign ltSigned   = $signed(bus.a) < $signed(bus.b);
  assign ltUnsigned = bus.a < bus.b;

  // ----------------------------------------
  // operation select
  // ----------------------------------------
  always_comb begin
    case (bus.ctrl)
      ctrlAdd:  resultComb = sum;
      ctrlSub:  resultComb = diff;
      ctrlAnd:  resultComb = bus.a & bus.b;
      ctrlOr:   resultComb = bus.a | bus.b;
      ctrlXor:  resultComb = bus.a ^ bus.b;
      // nor is the inverted or
      ctrlNor:  resultComb = ~(bus.a | bus.b);
      // set-less-than gives a single 1 or 0 in the low bit
      ctrlSlt:  resultComb = {{(dataWidth-1){1'b0}}, ltSigned};
      ctrlSltu: resultComb = {{(dataWidth-1){1'b0}}, ltUnsigned};
      // unknown field or explicit zero
      default:  resultComb = '0;
    endcase
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------
  assign bus.result = resultComb;

  // zero is high only for an all-zero result
  assign bus.zero = (resultComb == '0);

endmodule

// ==== verilog/executeStage.sv ====
// execute stage
//   immediate extension and operand-b select
//   stage 1 operand/control registers feeding the ALU
//   stage 2 result, zero and valid registers

`timescale 1ns/1ps

module executeStage
  import aluPkg::*;
#(
  parameter int dataWidth = 32
)
(
  input  logic                 begintest,
  input  logic                 reset,
  input  logic                 issue,
  input  aluCtrlT              ctrl,
  input  logic                 useImm,
  input  extModeT              extMode,
  input  logic [dataWidth-1:0] rsData,
  input  logic [dataWidth-1:0] rtData,
  input  logic [15:0]          imm,
  output logic                 resultValid,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  // extended immediate and selected second operand
  logic [dataWidth-1:0] immExt;
  logic [dataWidth-1:0] operandB;
  // stage 1 payload
  logic [dataWidth-1:0] aReg;
  logic [dataWidth-1:0] bReg;
  aluCtrlT              ctrlReg;
  // stage 1 valid
  logic                 valid1;

  aluIf #(.dataWidth(dataWidth)) aluBus ();

  // ----------------------------------------
  // operand select
  // ----------------------------------------
  always_comb begin
    if (extMode == extSign) begin
      immExt = {{(dataWidth-16){imm[15]}}, imm};
    end else begin
      immExt = {{(dataWidth-16){1'b0}}, imm};
    end
  end

  // b is the immediate for opImm and opMem, rt otherwise
  assign operandB = useImm ? immExt : rtData;

  // ----------------------------------------
  // stage 1
  // ----------------------------------------
  // payload only loads on an issue
  always_ff @(posedge begintest) begin
    if (issue) begin
      aReg    <= rsData;
      bReg    <= operandB;
      ctrlReg <= ctrl;
    end
  end

  always_ff @(posedge begintest) begin
    if (reset) begin
      valid1 <= 1'b0;
    end else begin
      valid1 <= issue;
    end
  end

  // stage 1 registers drive the ALU through the feed side
  assign aluBus.a    = aReg;
  assign aluBus.b    = bReg;
  assign aluBus.ctrl = ctrlReg;

  alu #(.dataWidth(dataWidth)) alu_inst (
    .bus (aluBus.core)
  );

  // ----------------------------------------
  // stage 2
  // ----------------------------------------
  always_ff @(posedge begintest) begin
    if (reset) begin
      resultValid <= 1'b0;
      result      <= '0;
      zero        <= 1'b0;
    end else begin
      // one-cycle pulse per issued operation
      resultValid <= valid1;
      // hold the last result between valid cycles
      if (valid1) begin
        result <= aluBus.result;
        zero   <= aluBus.zero;
      end
    end
  end

endmodule

// ==== verilog/aluExecTop.sv ====
// RTL top level of the execute path
//   ALU control decoder
//   two-stage execute pipeline around the ALU

`timescale 1ns/1ps

module aluExecTop
  import aluPkg::*;
#(
  parameter int dataWidth = 32
)
(
  input  logic                 begintest,
  input  logic                 reset,
  // issue side, sampled on the clock edge
  input  logic                 issue,
  input  logic [1:0]           aluOp,
  input  logic [5:0]           field,
  input  logic [dataWidth-1:0] rsData,
  input  logic [dataWidth-1:0] rtData,
  input  logic [15:0]          imm,
  // result side, two cycles after issue
  output logic                 resultValid,
  output logic [dataWidth-1:0] result,
  output logic                 zero
);

  // ----------------------------------------
  // decoder outputs
  // ----------------------------------------
  aluCtrlT ctrl;
  logic    useImm;
  extModeT extMode;

  // decoder is combinational, same cycle as issue
  aluDecode aluDecode_inst (
    .aluOp   (aluOpT'(aluOp)),
    .field   (field),
    .ctrl    (ctrl),
    .useImm  (useImm),
    .extMode (extMode)
  );

  // operand select and pipeline
  executeStage #(.dataWidth(dataWidth)) executeStage_inst (
    .begintest   (begintest),
    .reset       (reset),
    .issue       (issue),
    .ctrl        (ctrl),
    .useImm      (useImm),
    .extMode     (extMode),
    .rsData      (rsData),
    .rtData      (rtData),
    .imm         (imm),
    .resultValid (resultValid),
    .result      (result),
    .zero        (zero)
  );

endmodule

// ==== bench/aluExecModel.svh ====
// reference model of the execute path
//   expected ALU control code from operation class and field
//   expected second operand after immediate extension
//   expected ALU result

`ifndef ALU_EXEC_MODEL_SVH
`define ALU_EXEC_MODEL_SVH

// control code per class, unknown fields give ctrlZero
function automatic aluCtrlT expectedCtrl(input aluOpT op, input logic [5:0] fld);
  aluCtrlT c;
  c = ctrlZero;
  if (op == opMem) begin
    c = ctrlAdd;
  end else if (op == opBranch) begin
    c = ctrlSub;
  end else if (op == opRtype) begin
    case (fld)
      functAdd:  c = ctrlAdd;
      functSub:  c = ctrlSub;
      functAnd:  c = ctrlAnd;
      functOr:   c = ctrlOr;
      functXor:  c = ctrlXor;
      functNor:  c = ctrlNor;
      functSlt:  c = ctrlSlt;
      functSltu: c = ctrlSltu;
      default:   c = ctrlZero;
    endcase
  end else begin
    case (fld)
      opcAddi:  c = ctrlAdd;
      opcSlti:  c = ctrlSlt;
      opcSltiu: c = ctrlSltu;
      opcAndi:  c = ctrlAnd;
      opcOri:   c = ctrlOr;
      opcXori:  c = ctrlXor;
      default:  c = ctrlZero;
    endcase
  end
  return c;
endfunction

// rt for register and branch ops, extended immediate otherwise
function automatic logic [dataWidth-1:0] expectedOperandB(input aluOpT op,
    input logic [5:0] fld, input logic [dataWidth-1:0] rt, input logic [15:0] im);
  logic signed [dataWidth-1:0] sx;
  logic [dataWidth-1:0]        zx;
  sx = $signed(im);
  zx = im;
  if (op == opBranch || op == opRtype) begin
    return rt;
  end
  // only the logical immediates zero-extend
  if (op == opImm && (fld == opcAndi || fld == opcOri || fld == opcXori)) begin
    return zx;
  end
  return sx;
endfunction

function automatic logic [dataWidth-1:0] expectedResult(input aluCtrlT c,
    input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
  logic aNeg;
  logic bNeg;
  aNeg = a[dataWidth-1];
  bNeg = b[dataWidth-1];
  case (c)
    ctrlAdd:  return a + b;
    ctrlSub:  return a + ~b + 1'b1;
    ctrlAnd:  return a & b;
    ctrlOr:   return a | b;
    ctrlXor:  return a ^ b;
    ctrlNor:  return ~a & ~b;
    // differing signs decide directly, equal signs fall back to magnitude
    ctrlSlt:  return (aNeg != bNeg) ? dataWidth'(aNeg) : dataWidth'(a < b);
    ctrlSltu: return dataWidth'(a < b);
    default:  return '0;
  endcase
endfunction

`endif

// ==== bench/aluExecTb.sv ====
// testbench for the execute path
//   clock, reset, LCG random source, falling-edge stimulus
//   scoreboard queue checked by assertions on every rising edge
//   per-test report and closing counts

`timescale 1ns/1ps

module aluExecTb
  import aluPkg::*;
();

  localparam int dataWidth = 32;

  `include "aluExecModel.svh"

  logic                 begintest;
  logic                 reset;
  logic                 issue;
  logic [1:0]           aluOp;
  logic [5:0]           field;
  logic [dataWidth-1:0] rsData;
  logic [dataWidth-1:0] rtData;
  logic [15:0]          imm;
  logic                 resultValid;
  logic [dataWidth-1:0] result;
  logic                 zero;

  // expected {zero, result} per outstanding operation
  logic [dataWidth:0] expectQueue [$];
  // modeled valid bits of stage 1 and stage 2
  logic [1:0]         validPipe;
  logic               checksOn;
  logic [31:0]        lcgState;
  int                 errorCount;
  int                 checkCount;
  int                 testCount;
  int                 errorsAtStart;
  string              testName;

  aluExecTop #(.dataWidth(dataWidth)) aluExecTop_inst (
    .begintest   (begintest),
    .reset       (reset),
    .issue       (issue),
    .aluOp       (aluOp),
    .field       (field),
    .rsData      (rsData),
    .rtData      (rtData),
    .imm         (imm),
    .resultValid (resultValid),
    .result      (result),
    .zero        (zero)
  );

  // 40 ns period
  always #20 begintest = ~begintest;

  function automatic logic [31:0] nextRandom();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // ----------------------------------------
  // scoreboard, sampled on the rising edge
  // ----------------------------------------
  always @(posedge begintest) begin : scoreboard
    logic [dataWidth:0]   head;
    logic [dataWidth-1:0] bExp;
    logic [dataWidth-1:0] resExp;
    if (checksOn) begin
      // valid must follow each accepted issue by exactly 2 cycles
      checkCount++;
      assert (resultValid === validPipe[1]) else begin
        $display("ERR resultValid expected %h actual %h", validPipe[1], resultValid);
        errorCount++;
      end
      if (resultValid === 1'b1) begin
        assert (expectQueue.size() > 0) else begin
          $display("resultValid was high with no operation outstanding");
          errorCount++;
        end
        if (expectQueue.size() > 0) begin
          head = expectQueue.pop_front();
          checkCount++;
          assert (result === head[dataWidth-1:0]) else begin
            $display("ERR result expected %h actual %h", head[dataWidth-1:0], result);
            errorCount++;
          end
          assert (zero === head[dataWidth]) else begin
            $display("ERR zero expected %h actual %h", head[dataWidth], zero);
            errorCount++;
          end
        end
      end
    end
    // advance the modeled pipeline, reset drops everything in flight
    validPipe[1] = reset ? 1'b0 : validPipe[0];
    validPipe[0] = reset ? 1'b0 : issue;
    if (reset) begin
      expectQueue.delete();
      checksOn = 1'b1;
    end else if (issue) begin
      bExp   = expectedOperandB(aluOpT'(aluOp), field, rtData, imm);
      resExp = expectedResult(expectedCtrl(aluOpT'(aluOp), field), rsData, bExp);
      expectQueue.push_back({resExp == '0, resExp});
    end
  end

  // ----------------------------------------
  // stimulus helpers
  // ----------------------------------------
  // drive one operation for a single cycle
  task automatic issueOp(input aluOpT op, input logic [5:0] fld,
      input logic [dataWidth-1:0] rs, input logic [dataWidth-1:0] rt, input logic [15:0] im);
    issue  = 1'b1;
    aluOp  = op;
    field  = fld;
    rsData = rs;
    rtData = rt;
    imm    = im;
    @(negedge begintest);
  endtask

  // field biased toward valid functs and opcodes
  task automatic issueRandom();
    logic [31:0] r;
    aluOpT       op;
    logic [5:0]  fld;
    r  = nextRandom();
    op = aluOpT'(r[1:0]);
    if (op == opRtype) begin
      fld = {3'b100, r[4:2]};
    end else if (op == opImm) begin
      fld = {3'b001, r[4:2]};
    end else begin
      fld = r[7:2];
    end
    issueOp(op, fld, nextRandom(), nextRandom(), r[31:16]);
  endtask

  // every R-type funct back to back on the same operands
  task automatic issueAllFuncts(input logic [dataWidth-1:0] rs, input logic [dataWidth-1:0] rt);
    issueOp(opRtype, functAdd, rs, rt, 16'h0);
    issueOp(opRtype, functSub, rs, rt, 16'h0);
    issueOp(opRtype, functAnd, rs, rt, 16'h0);
    issueOp(opRtype, functOr, rs, rt, 16'h0);
    issueOp(opRtype, functXor, rs, rt, 16'h0);
    issueOp(opRtype, functNor, rs, rt, 16'h0);
    issueOp(opRtype, functSlt, rs, rt, 16'h0);
    issueOp(opRtype, functSltu, rs, rt, 16'h0);
  endtask

  // wait until every outstanding result has come back
  task automatic drainQueue();
    int waited;
    waited = 0;
    issue  = 1'b0;
    while (expectQueue.size() > 0 && waited < 20) begin
      @(negedge begintest);
      waited++;
    end
    if (expectQueue.size() > 0) begin
      $display("timeout, %0d results still outstanding after %0d cycles",
               expectQueue.size(), waited);
      errorCount++;
    end
  endtask

  task automatic beginTest(input string name);
    testName      = name;
    errorsAtStart = errorCount;
    testCount++;
  endtask

  task automatic endTest();
    drainQueue();
    $display("test %-16s %s (%0d errors)", testName,
             (errorCount == errorsAtStart) ? "ok" : "bad", errorCount - errorsAtStart);
  endtask

  // ----------------------------------------
  // test sequence
  // ----------------------------------------
  initial begin
    begintest  = 1'b0;
    reset      = 1'b1;
    issue      = 1'b0;
    aluOp      = 2'b00;
    field      = 6'h00;
    rsData     = '0;
    rtData     = '0;
    imm        = 16'h0;
    validPipe  = 2'b00;
    checksOn   = 1'b0;
    lcgState   = 32'hb0d9_e98d;
    errorCount = 0;
    checkCount = 0;
    testCount  = 0;
    repeat (4) @(negedge begintest);
    reset = 1'b0;

    beginTest("rtype");
    issueOp(opRtype, functAdd, 32'd30, 32'd1, 16'h0);
    drainQueue();
    issueOp(opRtype, functSub, 32'd45, 32'd5, 16'h0);
    drainQueue();
    // equal operands give a zero result
    issueOp(opRtype, functSub, 32'd7, 32'd7, 16'h0);
    drainQueue();
    issueOp(opRtype, functAnd, 32'hf0f0_1234, 32'h0ff0_ff00, 16'h0);
    drainQueue();
    issueOp(opRtype, functOr, 32'hf0f0_0000, 32'h0000_1234, 16'h0);
    drainQueue();
    issueOp(opRtype, functXor, 32'ha5a5_a5a5, 32'ha5a5_a5a5, 16'h0);
    drainQueue();
    issueOp(opRtype, functNor, 32'h0f0f_0000, 32'h0000_0f0f, 16'h0);
    drainQueue();
    issueOp(opRtype, functSlt, 32'd3, 32'd9, 16'h0);
    drainQueue();
    issueOp(opRtype, functSltu, 32'd9, 32'd3, 16'h0);
    drainQueue();
    repeat (4) issueAllFuncts(nextRandom(), nextRandom());
    endTest();

    beginTest("compare signs");
    issueOp(opRtype, functSlt, 32'hffff_ffff, 32'd1, 16'h0);
    issueOp(opRtype, functSltu, 32'hffff_ffff, 32'd1, 16'h0);
    // negative immediate becomes a large unsigned value
    issueOp(opImm, opcSltiu, 32'd5, 32'd0, 16'hfff0);
    // rs lies below the sign-extended immediate but above the zero-extended one
    issueOp(opImm, opcSltiu, 32'hffff_fff0, 32'd0, 16'hfffe);
    endTest();

    beginTest("imm extension");
    issueOp(opImm, opcAddi, 32'd16, 32'd0, 16'h8005);
    issueOp(opImm, opcSlti, 32'd0, 32'd0, 16'h8005);
    issueOp(opImm, opcAndi, 32'hffff_ffff, 32'd0, 16'h8005);
    issueOp(opImm, opcOri, 32'd0, 32'd0, 16'h8005);
    issueOp(opImm, opcXori, 32'hffff_0000, 32'd0, 16'h8005);
    issueOp(opImm, opcXori, 32'd5, 32'd0, 16'h0006);
    endTest();

    beginTest("mem and branch");
    issueOp(opMem, 6'h23, 32'h0000_1000, 32'd0, 16'hfffc);
    issueOp(opMem, 6'h2b, nextRandom(), nextRandom(), 16'h7ff0);
    issueOp(opBranch, 6'h04, 32'h1234_5678, 32'h1234_5678, 16'h0);
    issueOp(opBranch, 6'h04, 32'h1234_5678, 32'h1234_5679, 16'h0);
    endTest();

    beginTest("unknown codes");
    issueOp(opRtype, 6'b000001, 32'd11, 32'd22, 16'h0);
    issueOp(opImm, 6'b111111, 32'd11, 32'd22, 16'h1234);
    issueOp(opRtype, 6'b111111, 32'hffff_ffff, 32'd1, 16'h0);
    endTest();

    beginTest("pipeline");
    repeat (32) issueRandom();
    endTest();

    beginTest("reset mid-stream");
    repeat (6) issueRandom();
    reset = 1'b1;
    repeat (2) issueRandom();
    reset = 1'b0;
    issue = 1'b0;
    // resultValid must stay low while nothing is in flight
    repeat (3) @(negedge begintest);
    repeat (4) issueRandom();
    endTest();

    $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+bench
verilog/aluPkg.sv
verilog/aluIf.sv
verilog/aluDecode.sv
verilog/alu.sv
verilog/executeStage.sv
verilog/aluExecTop.sv
bench/aluExecTb.sv
